// ==== project.f ====
source/rv_pkg.sv
source/fetch_unit.sv
source/decoder.sv
source/reg_file.sv
source/hazard_unit.sv
source/execute_unit.sv
source/core_top.sv
tb/clock_gen.sv
tb/tb_core.sv

// ==== source/core_top.sv ====
`timescale 1ns/1ns

module core_top (
    input  logic                    clk,
    input  logic                    i_rst_n,
    // Instruction bus
    output logic [rv_pkg::XLEN-1:0] o_iad,
    input  logic [rv_pkg::XLEN-1:0] i_idt,
    input  logic                    i_acki_n,
    // Data bus
    output logic [rv_pkg::XLEN-1:0] o_dad,
    output logic [rv_pkg::XLEN-1:0] o_dwdata,
    input  logic [rv_pkg::XLEN-1:0] i_drdata,
    output logic                    o_mreq,
    output logic                    o_write,
    input  logic                    i_ackd_n
);

    logic                       stall;
    logic                       flush;
    logic                       freeze;
    rv_pkg::fwd_sel_e           fwd_a;
    rv_pkg::fwd_sel_e           fwd_b;

    logic [rv_pkg::XLEN-1:0]    if_pc;
    logic [rv_pkg::XLEN-1:0]    if_instr;
    logic                       if_valid;

    logic [rv_pkg::RADDR_W-1:0] id_rs1;
    logic [rv_pkg::RADDR_W-1:0] id_rs2;
    logic [rv_pkg::RADDR_W-1:0] id_rd;
    logic [rv_pkg::XLEN-1:0]    id_imm;
    rv_pkg::ctrl_t              id_ctrl;
    logic [rv_pkg::XLEN-1:0]    rf_rdata1;
    logic [rv_pkg::XLEN-1:0]    rf_rdata2;

    logic [rv_pkg::XLEN-1:0]    ex_result;
    logic [rv_pkg::XLEN-1:0]    ex_store_data;
    logic                       ex_redirect;
    logic [rv_pkg::XLEN-1:0]    ex_target;

    rv_pkg::id_ex_t             id_ex_d;
    rv_pkg::id_ex_t             id_ex_q;
    rv_pkg::ex_mem_t            ex_mem_d;
    rv_pkg::ex_mem_t            ex_mem_q;
    rv_pkg::mem_wb_t            mem_wb_d;
    rv_pkg::mem_wb_t            mem_wb_q;

    logic                       mem_access;
    logic                       mem_done_q;
    logic [rv_pkg::XLEN-1:0]    load_data_q;
    logic [rv_pkg::XLEN-1:0]    load_data;
    logic                       wb_write;

    fetch_unit u_fetch (
        .clk        (clk),
        .i_rst_n    (i_rst_n),
        .i_stall    (stall),
        .i_freeze   (freeze),
        .i_flush    (flush),
        .i_redirect (ex_redirect),
        .i_target   (ex_target),
        .i_instr    (i_idt),
        .o_pc       (o_iad),
        .o_if_pc    (if_pc),
        .o_if_instr (if_instr),
        .o_if_valid (if_valid)
    );

    decoder u_decoder (
        .i_instr (if_instr),
        .i_valid (if_valid),
        .o_rs1   (id_rs1),
        .o_rs2   (id_rs2),
        .o_rd    (id_rd),
        .o_imm   (id_imm),
        .o_ctrl  (id_ctrl)
    );

    reg_file u_reg_file (
        .clk      (clk),
        .i_rst_n  (i_rst_n),
        .i_we     (wb_write),
        .i_waddr  (mem_wb_q.rd),
        .i_wdata  (mem_wb_q.wb_value),
        .i_raddr1 (id_rs1),
        .i_raddr2 (id_rs2),
        .o_rdata1 (rf_rdata1),
        .o_rdata2 (rf_rdata2)
    );

    hazard_unit u_hazard (
        .i_id_rs1        (id_rs1),
        .i_id_rs2        (id_rs2),
        .i_ex_rd         (id_ex_q.rd),
        .i_ex_mem_read   (id_ex_q.ctrl.mem_read),
        .i_ex_valid      (id_ex_q.valid),
        .i_mem_rd        (ex_mem_q.rd),
        .i_mem_reg_write (ex_mem_q.ctrl.reg_write),
        .i_mem_is_mem    (mem_access),
        .i_mem_valid     (ex_mem_q.valid),
        .i_wb_rd         (mem_wb_q.rd),
        .i_wb_reg_write  (wb_write),
        .i_ex_rs1        (id_ex_q.rs1),
        .i_ex_rs2        (id_ex_q.rs2),
        .i_redirect      (ex_redirect),
        .i_acki_n        (i_acki_n),
        .i_ackd_n        (i_ackd_n),
        .o_fwd_a         (fwd_a),
        .o_fwd_b         (fwd_b),
        .o_stall         (stall),
        .o_flush         (flush),
        .o_freeze        (freeze)
    );

    execute_unit u_execute (
        .i_id_ex      (id_ex_q),
        .i_fwd_a      (fwd_a),
        .i_fwd_b      (fwd_b),
        .i_mem_fwd    (ex_mem_q.alu_result),
        .i_wb_fwd     (mem_wb_q.wb_value),
        .o_result     (ex_result),
        .o_store_data (ex_store_data),
        .o_redirect   (ex_redirect),
        .o_target     (ex_target)
    );

    always_comb begin
        id_ex_d.pc      = if_pc;
        id_ex_d.rs1_val = rf_rdata1;
        id_ex_d.rs2_val = rf_rdata2;
        id_ex_d.imm     = id_imm;
        id_ex_d.rs1     = id_rs1;
        id_ex_d.rs2     = id_rs2;
        id_ex_d.rd      = id_rd;
        id_ex_d.ctrl    = id_ctrl;
        // Bubble on load-use stall, killed on taken branch
        id_ex_d.valid   = if_valid && !stall && !flush;

        ex_mem_d.alu_result = ex_result;
        ex_mem_d.store_data = ex_store_data;
        ex_mem_d.rd         = id_ex_q.rd;
        ex_mem_d.ctrl       = id_ex_q.ctrl;
        ex_mem_d.valid      = id_ex_q.valid;

        mem_wb_d.wb_value  = ex_mem_q.ctrl.mem_read ? load_data : ex_mem_q.alu_result;
        mem_wb_d.rd        = ex_mem_q.rd;
        mem_wb_d.reg_write = ex_mem_q.ctrl.reg_write;
        mem_wb_d.valid     = ex_mem_q.valid;
    end

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            id_ex_q  <= '0;
            ex_mem_q <= '0;
            mem_wb_q <= '0;
        end else if (!freeze) begin
            id_ex_q  <= id_ex_d;
            ex_mem_q <= ex_mem_d;
            mem_wb_q <= mem_wb_d;
        end
    end

    // Data access finished while the fetch side still holds the pipe
    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            mem_done_q <= 1'b0;
        end else if (!freeze) begin
            mem_done_q <= 1'b0;
        end else if (mem_access && !i_ackd_n) begin
            mem_done_q <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (mem_access && !i_ackd_n) begin
            load_data_q <= i_drdata;
        end
    end

    assign mem_access = ex_mem_q.valid && !mem_done_q &&
                        (ex_mem_q.ctrl.mem_read || ex_mem_q.ctrl.mem_write);
    assign load_data  = mem_done_q ? load_data_q : i_drdata;

    assign o_mreq   = mem_access;
    assign o_write  = mem_access && ex_mem_q.ctrl.mem_write;
    assign o_dad    = ex_mem_q.alu_result;
    assign o_dwdata = ex_mem_q.store_data;

    assign wb_write = mem_wb_q.valid && mem_wb_q.reg_write;

endmodule

// ==== source/decoder.sv ====
`timescale 1ns/1ns

module decoder (
    input  logic [rv_pkg::XLEN-1:0]    i_instr,
    input  logic                       i_valid,
    output logic [rv_pkg::RADDR_W-1:0] o_rs1,
    output logic [rv_pkg::RADDR_W-1:0] o_rs2,
    output logic [rv_pkg::RADDR_W-1:0] o_rd,
    output logic [rv_pkg::XLEN-1:0]    o_imm,
    output rv_pkg::ctrl_t              o_ctrl
);

    logic [2:0]              funct3;
    logic [6:0]              funct7;
    logic [rv_pkg::XLEN-1:0] imm_i;
    logic [rv_pkg::XLEN-1:0] imm_s;
    logic [rv_pkg::XLEN-1:0] imm_b;
    logic [rv_pkg::XLEN-1:0] imm_u;
    logic [rv_pkg::XLEN-1:0] imm_j;

    assign funct3 = i_instr[14:12];
    assign funct7 = i_instr[31:25];
    assign o_rs1  = i_instr[19:15];
    assign o_rs2  = i_instr[24:20];
    assign o_rd   = i_instr[11:7];

    // Immediate formats
    assign imm_i = {{20{i_instr[31]}}, i_instr[31:20]};
    assign imm_s = {{20{i_instr[31]}}, i_instr[31:25], i_instr[11:7]};
    assign imm_b = {{20{i_instr[31]}}, i_instr[7], i_instr[30:25], i_instr[11:8], 1'b0};
    assign imm_u = {i_instr[31:12], 12'b0};
    assign imm_j = {{12{i_instr[31]}}, i_instr[19:12], i_instr[20], i_instr[30:21], 1'b0};

    always_comb begin
        o_ctrl = '0;
        o_imm  = imm_i;
        case (i_instr[6:0])
            rv_pkg::OP: begin
                o_ctrl.reg_write = 1'b1;
                case ({funct7, funct3})
                    {7'h00, 3'b000}: o_ctrl.alu_op = rv_pkg::ALU_ADD;
                    {7'h20, 3'b000}: o_ctrl.alu_op = rv_pkg::ALU_SUB;
                    {7'h00, 3'b111}: o_ctrl.alu_op = rv_pkg::ALU_AND;
                    {7'h00, 3'b110}: o_ctrl.alu_op = rv_pkg::ALU_OR;
                    {7'h00, 3'b100}: o_ctrl.alu_op = rv_pkg::ALU_XOR;
                    {7'h00, 3'b010}: o_ctrl.alu_op = rv_pkg::ALU_SLT;
                    default:         o_ctrl.reg_write = 1'b0;
                endcase
            end
            rv_pkg::OP_IMM: begin
                o_ctrl.use_imm   = 1'b1;
                o_ctrl.reg_write = 1'b1;
                case (funct3)
                    3'b000:  o_ctrl.alu_op = rv_pkg::ALU_ADD;
                    3'b111:  o_ctrl.alu_op = rv_pkg::ALU_AND;
                    3'b110:  o_ctrl.alu_op = rv_pkg::ALU_OR;
                    3'b100:  o_ctrl.alu_op = rv_pkg::ALU_XOR;
                    default: o_ctrl.reg_write = 1'b0;
                endcase
            end
            rv_pkg::LUI: begin
                o_ctrl.alu_op    = rv_pkg::ALU_PASS_B;
                o_ctrl.use_imm   = 1'b1;
                o_ctrl.reg_write = 1'b1;
                o_imm            = imm_u;
            end
            rv_pkg::LOAD: begin
                // Word access only
                o_ctrl.use_imm   = 1'b1;
                o_ctrl.mem_read  = (funct3 == 3'b010);
                o_ctrl.reg_write = (funct3 == 3'b010);
            end
            rv_pkg::STORE: begin
                o_ctrl.use_imm   = 1'b1;
                o_ctrl.mem_write = (funct3 == 3'b010);
                o_imm            = imm_s;
            end
            rv_pkg::BRANCH: begin
                // BEQ and BNE only
                o_ctrl.is_branch = (funct3[2:1] == 2'b00);
                o_ctrl.branch_ne = funct3[0];
                o_imm            = imm_b;
            end
            rv_pkg::JAL: begin
                o_ctrl.is_jal    = 1'b1;
                o_ctrl.reg_write = 1'b1;
                o_imm            = imm_j;
            end
            default: begin
                o_ctrl = '0;
            end
        endcase
        if (!i_valid) begin
            o_ctrl = '0;
        end
    end

endmodule

// ==== source/execute_unit.sv ====
`timescale 1ns/1ns

module execute_unit (
    input  rv_pkg::id_ex_t          i_id_ex,
    input  rv_pkg::fwd_sel_e        i_fwd_a,
    input  rv_pkg::fwd_sel_e        i_fwd_b,
    input  logic [rv_pkg::XLEN-1:0] i_mem_fwd,
    input  logic [rv_pkg::XLEN-1:0] i_wb_fwd,
    output logic [rv_pkg::XLEN-1:0] o_result,
    output logic [rv_pkg::XLEN-1:0] o_store_data,
    output logic                    o_redirect,
    output logic [rv_pkg::XLEN-1:0] o_target
);

    logic [rv_pkg::XLEN-1:0] op_a;
    logic [rv_pkg::XLEN-1:0] rs2_val;
    logic [rv_pkg::XLEN-1:0] op_b;
    logic [rv_pkg::XLEN-1:0] alu_out;
    logic                    taken;

    function automatic logic [rv_pkg::XLEN-1:0] fwd_pick(
        input rv_pkg::fwd_sel_e        sel,
        input logic [rv_pkg::XLEN-1:0] reg_val,
        input logic [rv_pkg::XLEN-1:0] mem_val,
        input logic [rv_pkg::XLEN-1:0] wb_val
    );
        case (sel)
            rv_pkg::FWD_MEM: fwd_pick = mem_val;
            rv_pkg::FWD_WB:  fwd_pick = wb_val;
            default:         fwd_pick = reg_val;
        endcase
    endfunction

    assign op_a    = fwd_pick(i_fwd_a, i_id_ex.rs1_val, i_mem_fwd, i_wb_fwd);
    assign rs2_val = fwd_pick(i_fwd_b, i_id_ex.rs2_val, i_mem_fwd, i_wb_fwd);
    assign op_b    = i_id_ex.ctrl.use_imm ? i_id_ex.imm : rs2_val;

    always_comb begin
        case (i_id_ex.ctrl.alu_op)
            rv_pkg::ALU_SUB:    alu_out = op_a - op_b;
            rv_pkg::ALU_AND:    alu_out = op_a & op_b;
            rv_pkg::ALU_OR:     alu_out = op_a | op_b;
            rv_pkg::ALU_XOR:    alu_out = op_a ^ op_b;
            rv_pkg::ALU_SLT:    alu_out = {{(rv_pkg::XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            rv_pkg::ALU_PASS_B: alu_out = op_b;
            default:            alu_out = op_a + op_b;
        endcase
    end

    // JAL writes its link address
    assign o_result     = i_id_ex.ctrl.is_jal ? i_id_ex.pc + rv_pkg::PC_STEP : alu_out;
    assign o_store_data = rs2_val;

    assign taken      = (op_a == rs2_val) != i_id_ex.ctrl.branch_ne;
    assign o_redirect = i_id_ex.valid &&
                        (i_id_ex.ctrl.is_jal || (i_id_ex.ctrl.is_branch && taken));
    assign o_target   = i_id_ex.pc + i_id_ex.imm;

endmodule

// ==== source/fetch_unit.sv ====
`timescale 1ns/1ns

module fetch_unit (
    input  logic                    clk,
    input  logic                    i_rst_n,
    input  logic                    i_stall,
    input  logic                    i_freeze,
    input  logic                    i_flush,
    input  logic                    i_redirect,
    input  logic [rv_pkg::XLEN-1:0] i_target,
    input  logic [rv_pkg::XLEN-1:0] i_instr,
    output logic [rv_pkg::XLEN-1:0] o_pc,
    output logic [rv_pkg::XLEN-1:0] o_if_pc,
    output logic [rv_pkg::XLEN-1:0] o_if_instr,
    output logic                    o_if_valid
);

    logic [rv_pkg::XLEN-1:0] pc_q;

    assign o_pc = pc_q;

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            pc_q       <= '0;
            o_if_valid <= 1'b0;
        end else if (!i_freeze) begin
            // Redirect wins over the load-use hold
            if (i_redirect) begin
                pc_q <= i_target;
            end else if (!i_stall) begin
                pc_q <= pc_q + rv_pkg::PC_STEP;
            end
            if (i_flush) begin
                o_if_valid <= 1'b0;
            end else if (!i_stall) begin
                o_if_valid <= 1'b1;
            end
        end
    end

    // IF/ID payload
    always_ff @(posedge clk) begin
        if (!i_freeze && !i_stall) begin
            o_if_pc    <= pc_q;
            o_if_instr <= i_instr;
        end
    end

endmodule

// ==== source/hazard_unit.sv ====
`timescale 1ns/1ns

module hazard_unit (
    input  logic [rv_pkg::RADDR_W-1:0] i_id_rs1,
    input  logic [rv_pkg::RADDR_W-1:0] i_id_rs2,
    input  logic [rv_pkg::RADDR_W-1:0] i_ex_rd,
    input  logic                       i_ex_mem_read,
    input  logic                       i_ex_valid,
    input  logic [rv_pkg::RADDR_W-1:0] i_mem_rd,
    input  logic                       i_mem_reg_write,
    input  logic                       i_mem_is_mem,
    input  logic                       i_mem_valid,
    input  logic [rv_pkg::RADDR_W-1:0] i_wb_rd,
    input  logic                       i_wb_reg_write,
    input  logic [rv_pkg::RADDR_W-1:0] i_ex_rs1,
    input  logic [rv_pkg::RADDR_W-1:0] i_ex_rs2,
    input  logic                       i_redirect,
    input  logic                       i_acki_n,
    input  logic                       i_ackd_n,
    output rv_pkg::fwd_sel_e           o_fwd_a,
    output rv_pkg::fwd_sel_e           o_fwd_b,
    output logic                       o_stall,
    output logic                       o_flush,
    output logic                       o_freeze
);

    logic mem_fwd_en;

    // Youngest producer first, never x0
    function automatic rv_pkg::fwd_sel_e fwd_src(
        input logic [rv_pkg::RADDR_W-1:0] rs,
        input logic                       mem_en,
        input logic [rv_pkg::RADDR_W-1:0] mem_rd,
        input logic                       wb_en,
        input logic [rv_pkg::RADDR_W-1:0] wb_rd
    );
        if (rs != '0 && mem_en && mem_rd == rs) begin
            fwd_src = rv_pkg::FWD_MEM;
        end else if (rs != '0 && wb_en && wb_rd == rs) begin
            fwd_src = rv_pkg::FWD_WB;
        end else begin
            fwd_src = rv_pkg::FWD_REG;
        end
    endfunction

    assign mem_fwd_en = i_mem_valid && i_mem_reg_write;

    assign o_fwd_a = fwd_src(i_ex_rs1, mem_fwd_en, i_mem_rd, i_wb_reg_write, i_wb_rd);
    assign o_fwd_b = fwd_src(i_ex_rs2, mem_fwd_en, i_mem_rd, i_wb_reg_write, i_wb_rd);

    // Load result is only ready from WB, so hold the consumer one slot
    assign o_stall = i_ex_valid && i_ex_mem_read && i_ex_rd != '0 &&
                     (i_ex_rd == i_id_rs1 || i_ex_rd == i_id_rs2);

    assign o_flush  = i_redirect;
    assign o_freeze = i_acki_n || (i_mem_is_mem && i_ackd_n);

endmodule

// ==== source/reg_file.sv ====
`timescale 1ns/1ns

module reg_file (
    input  logic                       clk,
    input  logic                       i_rst_n,
    input  logic                       i_we,
    input  logic [rv_pkg::RADDR_W-1:0] i_waddr,
    input  logic [rv_pkg::XLEN-1:0]    i_wdata,
    input  logic [rv_pkg::RADDR_W-1:0] i_raddr1,
    input  logic [rv_pkg::RADDR_W-1:0] i_raddr2,
    output logic [rv_pkg::XLEN-1:0]    o_rdata1,
    output logic [rv_pkg::XLEN-1:0]    o_rdata2
);

    logic [rv_pkg::XLEN-1:0] regs [rv_pkg::NREG];

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            for (int i = 0; i < rv_pkg::NREG; i++) begin
                regs[i] <= '0;
            end
        end else if (i_we && i_waddr != '0) begin
            regs[i_waddr] <= i_wdata;
        end
    end

    // x0 reads zero, a same-cycle write passes straight through
    assign o_rdata1 = (i_raddr1 == '0) ? '0 :
                      (i_we && i_waddr == i_raddr1) ? i_wdata : regs[i_raddr1];
    assign o_rdata2 = (i_raddr2 == '0) ? '0 :
                      (i_we && i_waddr == i_raddr2) ? i_wdata : regs[i_raddr2];

endmodule

// ==== source/rv_pkg.sv ====
package rv_pkg;

    localparam int XLEN    = 32;
    localparam int NREG    = 32;
    localparam int RADDR_W = $clog2(NREG);

    // Sequential fetch step
    localparam logic [XLEN-1:0] PC_STEP = 32'd4;

    // Major opcodes of the supported subset
    typedef enum logic [6:0] {
        OP     = 7'b0110011,
        OP_IMM = 7'b0010011,
        LUI    = 7'b0110111,
        LOAD   = 7'b0000011,
        STORE  = 7'b0100011,
        BRANCH = 7'b1100011,
        JAL    = 7'b1101111
    } opcode_e;

    typedef enum logic [2:0] {
        ALU_ADD    = 3'd0,
        ALU_SUB    = 3'd1,
        ALU_AND    = 3'd2,
        ALU_OR     = 3'd3,
        ALU_XOR    = 3'd4,
        ALU_SLT    = 3'd5,
        ALU_PASS_B = 3'd6
    } alu_op_e;

    // Source of an EX operand
    typedef enum logic [1:0] {
        FWD_REG = 2'd0,
        FWD_MEM = 2'd1,
        FWD_WB  = 2'd2
    } fwd_sel_e;

    typedef struct packed {
        alu_op_e alu_op;
        logic    use_imm;
        logic    reg_write;
        logic    mem_read;
        logic    mem_write;
        logic    is_branch;
        logic    branch_ne;
        logic    is_jal;
    } ctrl_t;

    typedef struct packed {
        logic [XLEN-1:0]    pc;
        logic [XLEN-1:0]    rs1_val;
        logic [XLEN-1:0]    rs2_val;
        logic [XLEN-1:0]    imm;
        logic [RADDR_W-1:0] rs1;
        logic [RADDR_W-1:0] rs2;
        logic [RADDR_W-1:0] rd;
        ctrl_t              ctrl;
        logic               valid;
    } id_ex_t;

    typedef struct packed {
        logic [XLEN-1:0]    alu_result;
        logic [XLEN-1:0]    store_data;
        logic [RADDR_W-1:0] rd;
        ctrl_t              ctrl;
        logic               valid;
    } ex_mem_t;

    typedef struct packed {
        logic [XLEN-1:0]    wb_value;
        logic [RADDR_W-1:0] rd;
        logic               reg_write;
        logic               valid;
    } mem_wb_t;

endpackage

// ==== tb/clock_gen.sv ====
`timescale 1ns/1ns

module clock_gen (
    output logic o_clk,
    output logic o_rst_n
);

    initial begin
        o_clk   = 1'b0;
        o_rst_n = 1'b0;
        repeat (3) @(posedge o_clk);
        o_rst_n <= 1'b1;
    end

    always #5 o_clk = ~o_clk;

endmodule

// ==== tb/tb_core.sv ====
`timescale 1ns/1ns

module tb_core;

    localparam int BODY      = 200;
    localparam int LOOP_IDX  = BODY + 15;
    localparam int MAX_STEPS = 5000;
    localparam int TIMEOUT   = 20000;
    localparam int RST_WAIT  = 10;

    logic        clk;
    logic        rst_n;
    logic [31:0] iad;
    logic [31:0] idt;
    logic        acki_n;
    logic [31:0] dad;
    logic [31:0] dwdata;
    logic [31:0] drdata;
    logic        mreq;
    logic        write;
    logic        ackd_n;

    logic [31:0] rom [256];
    logic [31:0] ram [256];
    logic [31:0] model_ram [256];
    logic [31:0] model_regs [32];
    logic [31:0] exp_addr [$];
    logic [31:0] exp_data [$];
    logic [31:0] rng_state = 32'd87990;
    int          iwait = 0;
    int          dwait = 0;
    int          stores_seen = 0;
    logic        prev_pending = 1'b0;
    logic [31:0] prev_dad;
    logic [31:0] prev_wdata;
    logic        prev_write;

    clock_gen u_clock (.o_clk(clk), .o_rst_n(rst_n));

    core_top uut (
        .clk (clk), .i_rst_n (rst_n),
        .o_iad (iad), .i_idt (idt), .i_acki_n (acki_n),
        .o_dad (dad), .o_dwdata (dwdata), .i_drdata (drdata),
        .o_mreq (mreq), .o_write (write), .i_ackd_n (ackd_n)
    );

    // Combinational memory read ports
    assign idt    = rom[iad[9:2]];
    assign drdata = ram[dad[9:2]];

    function automatic logic [31:0] next_rand();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    function automatic logic [4:0] pick_reg();
        return 5'(1 + next_rand() % 15);
    endfunction

    task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            $display("Mismatch %s expected %h actual %h", name, exp, act);
            $display("Test FAILED");
            $fatal(1);
        end
    endtask

    task automatic build_program();
        logic [2:0]  r_f3 [6];
        logic [6:0]  r_f7 [6];
        logic [2:0]  i_f3 [4];
        logic [11:0] imm;
        logic [12:0] boff;
        logic [20:0] joff;
        int          sel;
        int          kind;
        r_f3 = '{3'd0, 3'd0, 3'd7, 3'd6, 3'd4, 3'd2};
        r_f7 = '{7'h00, 7'h20, 7'h00, 7'h00, 7'h00, 7'h00};
        i_f3 = '{3'd0, 3'd7, 3'd6, 3'd4};
        for (int i = 0; i < 256; i++) begin
            rom[i] = 32'h0;
            ram[i] = (32'(i) * 32'h9e3779b9) ^ 32'h5a5a0000;
            model_ram[i] = ram[i];
        end
        for (int i = 0; i < BODY; i++) begin
            kind = next_rand() % 10;
            imm  = 12'(next_rand());
            // Branches need room for their forward target
            if (kind == 9 && i + 3 > BODY) begin
                kind = 4;
            end
            if (kind <= 3) begin
                sel = next_rand() % 6;
                rom[i] = {r_f7[sel], pick_reg(), pick_reg(), r_f3[sel], pick_reg(), 7'h33};
            end else if (kind <= 5) begin
                rom[i] = {imm, pick_reg(), i_f3[next_rand() % 4], pick_reg(), 7'h13};
            end else if (kind == 6) begin
                rom[i] = {20'(next_rand()), pick_reg(), 7'h37};
            end else if (kind == 7) begin
                rom[i] = {12'(4 * (next_rand() % 64)), 5'd0, 3'b010, pick_reg(), 7'h03};
            end else if (kind == 8) begin
                imm = 12'(4 * (next_rand() % 64));
                rom[i] = {imm[11:5], pick_reg(), 5'd0, 3'b010, imm[4:0], 7'h23};
            end else begin
                boff = 13'(4 * (2 + next_rand() % 2));
                joff = 21'(boff);
                sel  = next_rand() % 3;
                if (sel == 2) begin
                    rom[i] = {joff[20], joff[10:1], joff[11], joff[19:12], pick_reg(), 7'h6f};
                end else begin
                    rom[i] = {boff[12], boff[10:5], pick_reg(), pick_reg(), 3'(sel),
                              boff[4:1], boff[11], 7'h63};
                    // Same register on both sides gives a taken BEQ
                    if (next_rand() % 4 == 0) begin
                        rom[i][24:20] = rom[i][19:15];
                    end
                end
            end
        end
        // Epilogue dumps x1 to x15
        for (int r = 1; r <= 15; r++) begin
            imm = 12'(256 + 4 * (r - 1));
            rom[BODY + r - 1] = {imm[11:5], 5'(r), 5'd0, 3'b010, imm[4:0], 7'h23};
        end
        rom[LOOP_IDX] = 32'h0000006f;
    endtask

    task automatic run_model();
        logic [31:0] pc;
        logic [31:0] instr;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm_i;
        logic [31:0] addr;
        logic [31:0] nxt;
        int          steps;
        pc = 0;
        steps = 0;
        for (int r = 0; r < 32; r++) begin
            model_regs[r] = 0;
        end
        while (pc != 32'(LOOP_IDX * 4)) begin
            if (steps > MAX_STEPS) begin
                $display("Reference model did not reach the final loop");
                $display("Test FAILED");
                $fatal(1);
            end
            steps++;
            instr = rom[pc[9:2]];
            a     = model_regs[instr[19:15]];
            b     = model_regs[instr[24:20]];
            imm_i = {{20{instr[31]}}, instr[31:20]};
            nxt   = pc + 4;
            case (instr[6:0])
                7'h33: case (instr[14:12])
                    3'd0: model_regs[instr[11:7]] = instr[30] ? a - b : a + b;
                    3'd7: model_regs[instr[11:7]] = a & b;
                    3'd6: model_regs[instr[11:7]] = a | b;
                    3'd4: model_regs[instr[11:7]] = a ^ b;
                    default: model_regs[instr[11:7]] = 32'($signed(a) < $signed(b));
                endcase
                7'h13: case (instr[14:12])
                    3'd0: model_regs[instr[11:7]] = a + imm_i;
                    3'd7: model_regs[instr[11:7]] = a & imm_i;
                    3'd6: model_regs[instr[11:7]] = a | imm_i;
                    default: model_regs[instr[11:7]] = a ^ imm_i;
                endcase
                7'h37: model_regs[instr[11:7]] = {instr[31:12], 12'b0};
                7'h03: begin
                    addr = a + imm_i;
                    model_regs[instr[11:7]] = model_ram[addr[9:2]];
                end
                7'h23: begin
                    addr = a + {{20{instr[31]}}, instr[31:25], instr[11:7]};
                    model_ram[addr[9:2]] = b;
                    exp_addr.push_back(addr);
                    exp_data.push_back(b);
                end
                7'h63: if ((a == b) != instr[12]) begin
                    nxt = pc + {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
                end
                7'h6f: begin
                    model_regs[instr[11:7]] = pc + 4;
                    nxt = pc + {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
                end
                default: ;
            endcase
            model_regs[0] = 0;
            pc = nxt;
        end
    endtask

    // Acknowledges stay high 0 to 3 cycles, then low for one
    always @(posedge clk) begin
        if (iwait > 0) begin
            acki_n <= 1'b1;
            iwait  <= iwait - 1;
        end else begin
            acki_n <= 1'b0;
            iwait  <= next_rand() % 4;
        end
        if (dwait > 0) begin
            ackd_n <= 1'b1;
            dwait  <= dwait - 1;
        end else begin
            ackd_n <= 1'b0;
            dwait  <= next_rand() % 4;
        end
    end

    // Data bus monitor and RAM write port
    always @(posedge clk) begin
        if (rst_n) begin
            if (prev_pending) begin
                check_value("held request", 32'h1, 32'(mreq));
                check_value("held address", prev_dad, dad);
                check_value("held write data", prev_wdata, dwdata);
                check_value("held write strobe", 32'(prev_write), 32'(write));
            end
            prev_pending = mreq && ackd_n;
            prev_dad     = dad;
            prev_wdata   = dwdata;
            prev_write   = write;
            if (mreq && write && !ackd_n) begin
                if (stores_seen >= exp_addr.size()) begin
                    $display("DUT made more stores than the reference model");
                    $display("Test FAILED");
                    $fatal(1);
                end
                check_value("store address", exp_addr[stores_seen], dad);
                check_value("store data", exp_data[stores_seen], dwdata);
                ram[dad[9:2]] = dwdata;
                stores_seen++;
            end
        end
    end

    initial begin
        int cycles;
        acki_n = 1'b0;
        ackd_n = 1'b0;
        build_program();
        run_model();
        cycles = 0;
        while (rst_n !== 1'b1 && cycles < RST_WAIT) begin
            @(negedge clk);
            cycles++;
        end
        if (rst_n !== 1'b1) begin
            $display("Reset was never released");
            $display("Test FAILED");
            $fatal(1);
        end
        check_value("reset pc", 32'h0, iad);
        check_value("reset mreq", 32'h0, 32'(mreq));
        check_value("reset write", 32'h0, 32'(write));
        cycles = 0;
        while (stores_seen < exp_addr.size() && cycles < TIMEOUT) begin
            @(posedge clk);
            cycles++;
        end
        // Let any extra store show up
        repeat (50) @(posedge clk);
        if (stores_seen != exp_addr.size()) begin
            $display("Timeout waiting for stores, got %0d of %0d", stores_seen, exp_addr.size());
            $display("Test FAILED");
            $fatal(1);
        end else begin
            $display("Test OK");
            $finish;
        end
    end

endmodule
